// File: lsq.f
hdl/lsq_pkg.sv
hdl/lsq_ifs.sv
hdl/lsq_dispatch.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/mem_issue.sv
hdl/lsq_top.sv
testbench/tb_clock.sv
testbench/lsq_properties.sv
testbench/lsq_tb.sv

// File: testbench/lsq_tb.sv
// LSQ testbench
// Drives dispatch, CDB and ROB head, models memory with random accept
// and latency, and scores stores and load results in program order
`default_nettype none

module lsq_tb import lsq_pkg::*; ();
	localparam int    num_tests  = 6;
	localparam int    max_cycles = num_tests * 400;
	localparam word_t pattern    = 64'h5a5a5a5a5a5a5a5a;

	typedef struct {
		rob_idx_t rob;
		logic     is_store;
		logic     done;
		prf_tag_t dest;
		word_t    value;
	} rob_entry_t;
	typedef struct {
		word_t    address;
		word_t    data;
		rob_idx_t rob;
	} store_entry_t;
	typedef struct {
		mem_tag_t tag;
		word_t    data;
		int       due;
	} return_t;

	logic clock, reset, inst_valid, store_data_ready, cdb_valid, mispredict;
	logic result_valid, lsq_full;
	op_type_t inst_op_type;
	word_t base, offset, store_data, cdb_value, mem_data_in;
	word_t mem_address, mem_data, result_value;
	rob_idx_t rob_idx, rob_head, result_rob_idx;
	prf_tag_t dest_tag, cdb_tag, result_dest_tag;
	mem_tag_t mem_response, mem_tag_in;
	bus_command_t mem_command;

	rob_entry_t   rob_q[$];     // Outstanding instructions in age order
	store_entry_t store_q[$];   // Stores not yet seen on the bus
	return_t      return_q[$];  // Accepted loads waiting for data
	word_t        mem[word_t];
	word_t        ref_mem[word_t];    // Memory in program order
	rob_idx_t     next_rob = '0;
	prf_tag_t     next_dest = '0;
	mem_tag_t     next_tag = 4'd1;
	logic         refuse_all = 1'b0;
	logic         data_returned = 1'b0;    // Load data driven this cycle
	int cycles = 0, watchdog = 0, errors = 0, checks = 0, results = 0;
	int test_num = 1, error_mark = 0;

	tb_clock u_clock (.clock, .reset);
	lsq_top u_dut (.*);

	always @(posedge clock) begin
		watchdog++;
		if (watchdog > max_cycles) begin
			$display("Timeout after %0d cycles, LSQ stopped making progress", watchdog);
			$display("Errors found");
			$finish;
		end
	end

	function automatic int total_errors();
		return errors + u_dut.u_props.failures;
	endfunction

	task automatic check_value(string name, word_t got, word_t expected);
		checks++;
		assert (got === expected)
			else begin
				$display("MISMATCH %s got 0x%h expected 0x%h at cycle %0d", name, got,
					expected, cycles);
				errors++;
			end
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("ERROR %s at cycle %0d", what, cycles);
	endtask

	task automatic end_test(string name);
		$display("test %0d %s: %s", test_num, name,
			(total_errors() == error_mark) ? "pass" : "FAIL");
		test_num++;
		error_mark = total_errors();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model and scoreboard sampled at the falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic drive_cycle();
		cycles++;
		inst_valid = 1'b0;
		cdb_valid  = 1'b0;
		mispredict = 1'b0;
		rob_head   = (rob_q.size() != 0) ? rob_q[0].rob : next_rob;
		mem_response = (refuse_all || $urandom % 4 == 0) ? '0 : next_tag;
		if (return_q.size() != 0 && return_q[0].due <= cycles) begin
			mem_tag_in    = return_q[0].tag;
			mem_data_in   = return_q[0].data;
			data_returned = 1'b1;
			return_q.delete(0);
		end else begin
			mem_tag_in    = '0;
			mem_data_in   = '0;
			data_returned = 1'b0;
		end
	endtask

	function automatic int find_load(rob_idx_t idx);
		foreach (rob_q[i])
			if (!rob_q[i].is_store && !rob_q[i].done && rob_q[i].rob == idx)
				return i;
		return -1;
	endfunction

	task automatic observe();
		return_t pending;
		int      k;
		if (mem_command == bus_store && mem_response != 0) begin
			if (store_q.size() == 0) begin
				report_failure("store on the memory bus with no store pending");
			end else begin
				check_value("mem_address", mem_address, store_q[0].address);
				check_value("mem_data", mem_data, store_q[0].data);
				check_value("rob_head", 64'(rob_head), 64'(store_q[0].rob));
				mem[store_q[0].address] = store_q[0].data;
				foreach (rob_q[i])
					if (rob_q[i].is_store && rob_q[i].rob == store_q[0].rob)
						rob_q[i].done = 1'b1;
				store_q.delete(0);
			end
		end
		if (mem_command == bus_load && mem_response != 0) begin
			pending.tag  = mem_response;
			pending.data = mem.exists(mem_address) ? mem[mem_address] : mem_address ^ pattern;
			pending.due  = cycles + 2 + $urandom % 5;
			return_q.push_back(pending);
		end
		if (mem_command != bus_none && mem_response != 0)
			next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 1'b1;
		if (result_valid === 1'b1) begin
			results++;
			k = find_load(result_rob_idx);
			if (k < 0) begin
				report_failure("load result with no matching outstanding load");
			end else begin
				check_value("result_value", result_value, rob_q[k].value);
				check_value("result_dest_tag", 64'(result_dest_tag), 64'(rob_q[k].dest));
				rob_q[k].done = 1'b1;
			end
		end
		while (rob_q.size() != 0 && rob_q[0].done)
			rob_q.delete(0);
		if (mispredict) begin     // Everything in flight is squashed
			rob_q.delete();
			store_q.delete();
			return_q.delete();
			ref_mem = mem;
		end
	endtask

	task automatic cycle();
		@(negedge clock);
		observe();
		@(posedge clock);
		#1 drive_cycle();
	endtask

	task automatic drain();
		while (rob_q.size() != 0)
			cycle();
		repeat (4) cycle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Dispatch helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic present(op_type_t op, word_t address);
		while (lsq_full)
			cycle();
		offset           = $urandom % 256;
		base             = address - offset;
		inst_valid       = 1'b1;
		inst_op_type     = op;
		rob_idx          = next_rob;
		dest_tag         = next_dest;
		store_data       = '0;
		store_data_ready = 1'b1;
	endtask

	task automatic issue_load(word_t address);
		rob_entry_t e;
		present(op_ldq, address);
		e.rob      = next_rob;
		e.is_store = 1'b0;
		e.done     = 1'b0;
		e.dest     = next_dest;
		e.value    = ref_mem.exists(address) ? ref_mem[address] : address ^ pattern;
		rob_q.push_back(e);
		next_rob++;
		next_dest++;
		cycle();
	endtask

	task automatic issue_store(word_t address, word_t data, logic ready, prf_tag_t tag,
		logic cdb_now);
		rob_entry_t e;
		present(op_stq, address);
		store_data       = ready ? data : word_t'(tag);    // Tag rides in the data field
		store_data_ready = ready;
		if (cdb_now) begin
			cdb_valid = 1'b1;
			cdb_tag   = tag;
			cdb_value = data;
		end
		e.rob      = next_rob;
		e.is_store = 1'b1;
		e.done     = 1'b0;
		e.dest     = '0;
		e.value    = '0;
		rob_q.push_back(e);
		store_q.push_back('{address, data, next_rob});
		ref_mem[address] = data;
		next_rob++;
		cycle();
	endtask

	task automatic broadcast(prf_tag_t tag, word_t value);
		cdb_valid = 1'b1;
		cdb_tag   = tag;
		cdb_value = value;
		cycle();
	endtask

	function automatic word_t pick_address();
		return 64'h8000_0000 + 64'(($urandom % 4) << 3);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int    mark;
		word_t address;
		void'($urandom(32'hfa1e677e));
		inst_valid       = 1'b0;
		inst_op_type     = '0;
		base             = '0;
		offset           = '0;
		store_data       = '0;
		store_data_ready = 1'b0;
		rob_idx          = '0;
		dest_tag         = '0;
		cdb_valid        = 1'b0;
		cdb_tag          = '0;
		cdb_value        = '0;
		rob_head         = '0;
		mispredict       = 1'b0;
		mem_response     = '0;
		mem_tag_in       = '0;
		mem_data_in      = '0;
		@(negedge reset);

		@(negedge clock);
		check_value("mem_command", 64'(mem_command), 64'(bus_none));
		check_value("result_valid", 64'(result_valid), 64'd0);
		check_value("lsq_full", 64'(lsq_full), 64'd0);
		@(posedge clock);
		#1 drive_cycle();
		end_test("reset state");

		for (int i = 0; i < 6; i++)
			issue_store(pick_address() + 64'(i * 32), {$urandom, $urandom}, 1'b1, '0, 1'b0);
		drain();
		end_test("store order");

		address = pick_address();
		issue_store(address, 64'h1111_2222_3333_4444, 1'b0, 6'd10, 1'b1);
		issue_store(address + 8, 64'h5555_6666_7777_8888, 1'b0, 6'd11, 1'b0);
		broadcast(6'd11, 64'h5555_6666_7777_8888);    // Hits the dispatch register
		issue_store(address, 64'h9999_aaaa_bbbb_cccc, 1'b0, 6'd12, 1'b0);
		repeat (3) cycle();
		broadcast(6'd12, 64'h9999_aaaa_bbbb_cccc);
		issue_load(address);
		drain();
		end_test("late store data");

		for (int i = 0; i < 24; i++) begin
			if ($urandom % 2)
				issue_load(pick_address());
			else
				issue_store(pick_address(), {$urandom, $urandom}, 1'b1, '0, 1'b0);
			if ($urandom % 4 == 0)
				cycle();
		end
		drain();
		end_test("load values");

		mark       = results;
		refuse_all = 1'b1;
		for (int i = 0; i < 8; i++)
			issue_load(pick_address() + 64'(i * 64));
		repeat (2) cycle();
		check_value("lsq_full", 64'(lsq_full), 64'd1);
		refuse_all = 1'b0;
		drain();
		check_value("result count", 64'(results - mark), 64'd8);
		end_test("full queue");

		address = pick_address();
		issue_load(address + 24);    // Older than the store so it reaches memory
		issue_store(address, 64'hdead_0000_0000_beef, 1'b0, 6'd20, 1'b0);
		issue_load(address);
		issue_load(address + 8);
		while (!data_returned)
			cycle();
		cycle();                     // Returned load now sits filled
		present(op_ldq, address + 16);    // Dropped along with the flush
		mispredict = 1'b1;
		cycle();
		broadcast(6'd20, 64'hdead_0000_0000_beef);
		repeat (6) cycle();
		issue_store(address, 64'h0123_4567_89ab_cdef, 1'b1, '0, 1'b0);
		issue_load(address);
		issue_load(address + 8);
		drain();
		end_test("mispredict");

		$display("tests %0d, checks %0d, errors %0d", test_num - 1, checks, total_errors());
		if (total_errors() == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end
endmodule

`default_nettype wire

// File: testbench/lsq_properties.sv
// LSQ bound checks
// Store commit order, quiet result port around a flush, idle state out of reset
`default_nettype none

module lsq_properties import lsq_pkg::*; (
	input logic         clock,
	input logic         reset,
	input logic         mispredict,
	input rob_idx_t     rob_head,
	input rob_idx_t     sq_rob_idx,
	input bus_command_t mem_command,
	input logic         result_valid,
	input logic         lsq_full
);
	int failures = 0;

	// Oldest store only goes out at the retire head
	store_at_commit: assert property (@(posedge clock) disable iff (reset)
		mem_command == bus_store |-> sq_rob_idx == rob_head)
		else begin
			$error("store issued before its ROB entry reached the retire head");
			failures++;
		end

	flush_quiet: assert property (@(posedge clock) disable iff (reset)
		mispredict |-> !result_valid ##1 !result_valid)
		else begin
			$error("load result reported right after a mispredict");
			failures++;
		end

	reset_idle: assert property (@(posedge clock)
		$fell(reset) |-> !lsq_full && mem_command == bus_none && !result_valid)
		else begin
			$error("LSQ not idle after reset");
			failures++;
		end
endmodule

bind lsq_top lsq_properties u_props (
	.clock        (clock),
	.reset        (reset),
	.mispredict   (mispredict),
	.rob_head     (rob_head),
	.sq_rob_idx   (sq_head.head_rob_idx),
	.mem_command  (mem_command),
	.result_valid (result_valid),
	.lsq_full     (lsq_full)
);

`default_nettype wire

// File: testbench/tb_clock.sv
// Testbench clock and reset
// 8 unit clock period, reset held high for the first 16 cycles
`default_nettype none

module tb_clock (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;
	end
endmodule

`default_nettype wire

// File: hdl/lsq_top.sv
// Load/store queue top level
// Dispatch, load and store queues and memory issue for one thread
`default_nettype none

module lsq_top import lsq_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         inst_valid,
	input  op_type_t     inst_op_type,
	input  word_t        base,
	input  word_t        offset,
	input  word_t        store_data,
	input  logic         store_data_ready,
	input  rob_idx_t     rob_idx,
	input  prf_tag_t     dest_tag,
	input  logic         cdb_valid,
	input  prf_tag_t     cdb_tag,
	input  word_t        cdb_value,
	input  rob_idx_t     rob_head,
	input  logic         mispredict,
	input  mem_tag_t     mem_response,
	input  mem_tag_t     mem_tag_in,
	input  word_t        mem_data_in,
	output bus_command_t mem_command,
	output word_t        mem_address,
	output word_t        mem_data,
	output logic         result_valid,
	output word_t        result_value,
	output prf_tag_t     result_dest_tag,
	output rob_idx_t     result_rob_idx,
	output logic         lsq_full
);
	logic lq_full;
	logic sq_full;

	alloc_if      alloc ();
	store_head_if sq_head ();
	load_port_if  lq_port ();

	lsq_dispatch u_dispatch (.*);

	store_queue u_store_queue (
		.head (sq_head),
		.full (sq_full),
		.*
	);

	load_queue u_load_queue (
		.sq_head_rob_idx (sq_head.head_rob_idx),
		.sq_empty        (sq_head.empty),
		.port            (lq_port),
		.full            (lq_full),
		.*
	);

	mem_issue u_mem_issue (
		.head (sq_head),
		.port (lq_port),
		.*
	);

	assign lsq_full = lq_full || sq_full;

endmodule

`default_nettype wire

// File: hdl/mem_issue.sv
// Memory issue and result select
// Chooses between the committing store and the picked load, tracks
// accepted load tags and forwards load results to the result port
`default_nettype none

module mem_issue import lsq_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  rob_idx_t      rob_head,
	input  logic          mispredict,
	input  mem_tag_t      mem_response,
	input  mem_tag_t      mem_tag_in,
	input  word_t         mem_data_in,
	store_head_if.issue   head,
	load_port_if.issue    port,
	output bus_command_t  mem_command,
	output word_t         mem_address,
	output word_t         mem_data,
	output logic          result_valid,
	output word_t         result_value,
	output prf_tag_t      result_dest_tag,
	output rob_idx_t      result_rob_idx
);
	logic                store_go;
	logic                load_go;
	logic                accepted;
	logic [mem_tags-1:0] tag_valid;
	lq_idx_t             tag_slot [mem_tags];

	//////////////////////////////////////////////////////////////////////////
	// Request arbitration
	//////////////////////////////////////////////////////////////////////////
	// Store only at its commit, and it wins over any load
	assign store_go = head.head_valid && head.head_data_ready &&
		(head.head_rob_idx == rob_head) && !mispredict;
	assign load_go  = !store_go && port.pick_valid && !mispredict;
	assign accepted = (mem_response != '0);

	always_comb begin
		if (store_go)
			mem_command = bus_store;
		else if (load_go)
			mem_command = bus_load;
		else
			mem_command = bus_none;
	end

	assign mem_address = store_go ? head.head_address : port.pick_address;
	assign mem_data    = head.head_data;

	// Refused requests are simply offered again next cycle
	assign head.retire    = store_go && accepted;
	assign port.requested = load_go && accepted;

	//////////////////////////////////////////////////////////////////////////
	// Tag table
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			tag_valid <= '0;
		end else begin
			if (tag_valid[mem_tag_in])
				tag_valid[mem_tag_in] <= 1'b0;
			if (port.requested)
				tag_valid[mem_response] <= 1'b1;    // Reuse of a returning tag wins
		end
	end

	always_ff @(posedge clock) begin
		if (port.requested)
			tag_slot[mem_response] <= port.pick_slot;
	end

	assign port.fill_valid = tag_valid[mem_tag_in];
	assign port.fill_slot  = tag_slot[mem_tag_in];
	assign port.fill_data  = mem_data_in;

	// One result per cycle, always taken
	assign result_valid      = port.result_valid;
	assign result_value      = port.result_value;
	assign result_dest_tag   = port.result_dest_tag;
	assign result_rob_idx    = port.result_rob_idx;
	assign port.result_taken = port.result_valid;

endmodule

`default_nettype wire

// File: hdl/load_queue.sv
// Load queue
// Unordered load slots; picks the lowest load that is older than every
// pending store, takes returned data and offers one result per cycle
`default_nettype none

module load_queue import lsq_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  rob_idx_t   rob_head,
	input  logic       mispredict,
	alloc_if.queue     alloc,
	input  rob_idx_t   sq_head_rob_idx,
	input  logic       sq_empty,
	load_port_if.queue port,
	output logic       full
);
	logic [lq_depth-1:0]       valid;
	logic [lq_depth-1:0]       requested;
	logic [lq_depth-1:0]       filled;
	logic [lq_depth-1:0]       eligible;
	word_t                     address [lq_depth];
	word_t                     value [lq_depth];
	rob_idx_t                  rob_idx [lq_depth];
	prf_tag_t                  dest_tag [lq_depth];
	rob_idx_t                  load_age [lq_depth];
	rob_idx_t                  store_age;
	lq_idx_t                   free_slot;
	logic [$clog2(lq_depth):0] free_count;

	// Distance from the retire point, wraps with the ROB
	assign store_age = sq_head_rob_idx - rob_head;

	always_comb begin
		for (int i = 0; i < lq_depth; i++) begin
			load_age[i] = rob_idx[i] - rob_head;
			eligible[i] = valid[i] && !requested[i] && (sq_empty || load_age[i] < store_age);
		end
	end

	always_comb begin
		free_slot  = '0;
		free_count = '0;
		for (int i = lq_depth - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_slot  = lq_idx_t'(i);
				free_count = free_count + 1'b1;
			end
		end
	end

	assign full = (free_count == 0) || (free_count == 1 && alloc.load_valid);

	//////////////////////////////////////////////////////////////////////////
	// Memory pick and result select, lowest slot wins
	//////////////////////////////////////////////////////////////////////////
	always_comb begin
		port.pick_valid  = |eligible;
		port.pick_slot   = '0;
		port.result_slot = '0;
		for (int i = lq_depth - 1; i >= 0; i--) begin
			if (eligible[i])
				port.pick_slot = lq_idx_t'(i);
			if (filled[i])
				port.result_slot = lq_idx_t'(i);
		end
	end

	assign port.pick_address    = address[port.pick_slot];
	assign port.result_valid    = |filled && !mispredict;    // Flushed loads never report
	assign port.result_value    = value[port.result_slot];
	assign port.result_dest_tag = dest_tag[port.result_slot];
	assign port.result_rob_idx  = rob_idx[port.result_slot];

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			valid     <= '0;
			requested <= '0;
			filled    <= '0;
		end else begin
			if (alloc.load_valid) begin
				valid[free_slot]     <= 1'b1;
				requested[free_slot] <= 1'b0;
				filled[free_slot]    <= 1'b0;
			end
			if (port.requested)
				requested[port.pick_slot] <= 1'b1;
			if (port.fill_valid)
				filled[port.fill_slot] <= 1'b1;
			if (port.result_taken) begin      // Slot done
				valid[port.result_slot]  <= 1'b0;
				filled[port.result_slot] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (alloc.load_valid) begin
			address[free_slot]  <= alloc.address;
			rob_idx[free_slot]  <= alloc.rob_idx;
			dest_tag[free_slot] <= alloc.dest_tag;
		end
		if (port.fill_valid)
			value[port.fill_slot] <= port.fill_data;
	end

endmodule

`default_nettype wire

// File: hdl/store_queue.sv
// Store queue
// Circular buffer in program order; entries wait on the CDB for their
// data and leave from the head when memory takes them
`default_nettype none

module store_queue import lsq_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     cdb_valid,
	input  prf_tag_t cdb_tag,
	input  word_t    cdb_value,
	input  logic     mispredict,
	alloc_if.queue   alloc,
	store_head_if.queue head,
	output logic     full
);
	logic [sq_depth-1:0] valid;
	logic [sq_depth-1:0] data_ready;
	logic [sq_depth-1:0] cdb_hit;
	word_t               address [sq_depth];
	word_t               data [sq_depth];
	prf_tag_t            data_tag [sq_depth];
	rob_idx_t            rob_idx [sq_depth];
	sq_idx_t             head_ptr;
	sq_idx_t             tail_ptr;
	sq_idx_t             tail_next;
	logic                alloc_hit;

	assign tail_next = tail_ptr + 1'b1;

	// CDB may broadcast while the entry is still in the dispatch register
	assign alloc_hit = !alloc.data_ready && cdb_valid && (cdb_tag == alloc.data_tag);

	always_comb begin
		for (int i = 0; i < sq_depth; i++) begin
			cdb_hit[i] = valid[i] && !data_ready[i] && cdb_valid && (cdb_tag == data_tag[i]);
		end
	end

	// Counts the entry being written this cycle as taken
	assign full = valid[tail_ptr] || (alloc.store_valid && valid[tail_next]);

	//////////////////////////////////////////////////////////////////////////
	// Pointers and entry status
	//////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			head_ptr   <= '0;
			tail_ptr   <= '0;
			valid      <= '0;
			data_ready <= '0;
		end else begin
			for (int i = 0; i < sq_depth; i++) begin
				if (cdb_hit[i])
					data_ready[i] <= 1'b1;
			end
			if (alloc.store_valid) begin
				valid[tail_ptr]      <= 1'b1;
				data_ready[tail_ptr] <= alloc.data_ready || alloc_hit;
				tail_ptr             <= tail_next;
			end
			if (head.retire) begin
				valid[head_ptr] <= 1'b0;
				head_ptr        <= head_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < sq_depth; i++) begin
			if (cdb_hit[i])
				data[i] <= cdb_value;
		end
		if (alloc.store_valid) begin
			address[tail_ptr]  <= alloc.address;
			data[tail_ptr]     <= alloc_hit ? cdb_value : alloc.data;
			data_tag[tail_ptr] <= alloc.data_tag;
			rob_idx[tail_ptr]  <= alloc.rob_idx;
		end
	end

	// Head is always the oldest store
	assign head.head_valid      = valid[head_ptr];
	assign head.head_data_ready = data_ready[head_ptr];
	assign head.head_address    = address[head_ptr];
	assign head.head_data       = data[head_ptr];
	assign head.head_rob_idx    = rob_idx[head_ptr];
	assign head.empty           = !valid[head_ptr];

endmodule

`default_nettype wire

// File: hdl/lsq_dispatch.sv
// LSQ dispatch stage
// Decodes one memory instruction per cycle, forms its address and
// registers the queue write; late store data is picked off the CDB
`default_nettype none

module lsq_dispatch import lsq_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     inst_valid,
	input  op_type_t inst_op_type,
	input  word_t    base,
	input  word_t    offset,
	input  word_t    store_data,
	input  logic     store_data_ready,
	input  rob_idx_t rob_idx,
	input  prf_tag_t dest_tag,
	input  logic     cdb_valid,
	input  prf_tag_t cdb_tag,
	input  word_t    cdb_value,
	input  logic     mispredict,
	alloc_if.dispatch alloc
);
	logic     is_load;
	logic     is_store;
	logic     cdb_hit;
	prf_tag_t data_tag;

	assign is_load  = inst_valid && (inst_op_type == op_ldq);
	assign is_store = inst_valid && (inst_op_type == op_stq);

	// Store data field holds the producer tag until the value is ready
	assign data_tag = prf_tag_t'(store_data);
	assign cdb_hit  = !store_data_ready && cdb_valid && (cdb_tag == data_tag);

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin    // Dispatch in a flush cycle is dropped
			alloc.load_valid  <= 1'b0;
			alloc.store_valid <= 1'b0;
		end else begin
			alloc.load_valid  <= is_load;
			alloc.store_valid <= is_store;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			alloc.address    <= base + offset;
			alloc.data       <= cdb_hit ? cdb_value : store_data;
			alloc.data_ready <= store_data_ready || cdb_hit;
			alloc.data_tag   <= data_tag;
			alloc.rob_idx    <= rob_idx;
			alloc.dest_tag   <= dest_tag;
		end
	end

endmodule

`default_nettype wire

// File: hdl/lsq_ifs.sv
// Internal LSQ interfaces
// Dispatch to queues, store queue head to memory issue, and the
// load queue port shared with memory issue
`default_nettype none

interface alloc_if import lsq_pkg::*; ();
	logic     load_valid;   // One-cycle strobe, written at the next edge
	logic     store_valid;
	word_t    address;
	word_t    data;
	logic     data_ready;
	prf_tag_t data_tag;     // Producer of store data when not ready
	rob_idx_t rob_idx;
	prf_tag_t dest_tag;

	modport dispatch (output load_valid, store_valid, address, data, data_ready, data_tag,
		rob_idx, dest_tag);
	modport queue (input load_valid, store_valid, address, data, data_ready, data_tag,
		rob_idx, dest_tag);
endinterface

interface store_head_if import lsq_pkg::*; ();
	logic     head_valid;
	logic     head_data_ready;
	word_t    head_address;
	word_t    head_data;
	rob_idx_t head_rob_idx;
	logic     empty;
	logic     retire;       // Frees the head entry

	modport queue (output head_valid, head_data_ready, head_address, head_data,
		head_rob_idx, empty, input retire);
	modport issue (input head_valid, head_data_ready, head_address, head_data,
		head_rob_idx, empty, output retire);
endinterface

interface load_port_if import lsq_pkg::*; ();
	logic     pick_valid;
	lq_idx_t  pick_slot;
	word_t    pick_address;
	logic     result_valid;
	lq_idx_t  result_slot;
	word_t    result_value;
	prf_tag_t result_dest_tag;
	rob_idx_t result_rob_idx;
	logic     requested;    // Applies to pick_slot
	logic     fill_valid;
	lq_idx_t  fill_slot;
	word_t    fill_data;
	logic     result_taken;

	modport queue (output pick_valid, pick_slot, pick_address, result_valid, result_slot,
		result_value, result_dest_tag, result_rob_idx,
		input requested, fill_valid, fill_slot, fill_data, result_taken);
	modport issue (input pick_valid, pick_slot, pick_address, result_valid, result_slot,
		result_value, result_dest_tag, result_rob_idx,
		output requested, fill_valid, fill_slot, fill_data, result_taken);
endinterface

`default_nettype wire

// File: hdl/lsq_pkg.sv
// Load/store queue shared definitions
// Widths, queue depths, opcodes and the memory bus command
`default_nettype none

package lsq_pkg;

	localparam int xlen      = 64;
	localparam int rob_depth = 32;
	localparam int prf_depth = 64;
	localparam int lq_depth  = 8;
	localparam int sq_depth  = 8;
	localparam int mem_tags  = 16;     // Tag 0 is never handed out by memory

	typedef logic [xlen-1:0]              word_t;
	typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
	typedef logic [$clog2(prf_depth)-1:0] prf_tag_t;
	typedef logic [$clog2(lq_depth)-1:0]  lq_idx_t;
	typedef logic [$clog2(sq_depth)-1:0]  sq_idx_t;
	typedef logic [$clog2(mem_tags)-1:0]  mem_tag_t;
	typedef logic [5:0]                   op_type_t;

	// Memory opcodes, everything else is ignored at dispatch
	localparam op_type_t op_ldq = 6'h29;
	localparam op_type_t op_stq = 6'h2d;

	typedef enum logic [1:0] {
		bus_none,
		bus_load,
		bus_store
	} bus_command_t;

endpackage

`default_nettype wire
